// File: ex_top.f
+incdir+test
verilog/ex_pkg.sv
verilog/pipe_reg.sv
verilog/forward_unit.sv
verilog/operand_select.sv
verilog/alu.sv
verilog/ex_stage.sv
verilog/ex_top.sv
test/ex_tb.sv

// File: Makefile
# Verilator build and run of the EX stage testbench

VERILATOR ?= verilator
TOP       ?= ex_tb
FILELIST  ?= ex_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

FAIL_MSG := Done: errors found
PASS_MSG := Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/ex_tb_model.svh
`ifndef EX_TB_MODEL_SVH
`define EX_TB_MODEL_SVH

  ////////////////////////////////////////
  // Random source
  ////////////////////////////////////////

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Younger MEM write beats WB, r0 always reads the register file
  function automatic logic [LEN-1:0] fwd_value(input logic [NB_REG-1:0] r,
                                               input logic [LEN-1:0] rf,
                                               input fwd_port_t mem,
                                               input fwd_port_t wb);
    if (r == '0)
      return rf;
    if (mem.reg_write && (mem.write_reg == r))
      return mem.data;
    if (wb.reg_write && (wb.write_reg == r))
      return wb.data;
    return rf;
  endfunction

  function automatic ex_mem_t exp_ex_mem(input id_ex_t id, input fwd_port_t mem,
                                         input fwd_port_t wb);
    ex_mem_t          e;
    logic [LEN-1:0]   rs_v;
    logic [LEN-1:0]   rt_v;
    logic [LEN-1:0]   a;
    logic [LEN-1:0]   b;
    logic [LEN-1:0]   r;
    logic [LEN-1:0]   msb;
    logic [2*LEN-1:0] ext;
    logic [4:0]       sh;
    alu_op_e          op;
    rs_v = fwd_value(id.rs, id.rs_data, mem, wb);
    rt_v = fwd_value(id.rt, id.rt_data, mem, wb);
    a    = id.ex.src_a_shamt ? LEN'(id.shamt) : rs_v;
    b    = id.ex.src_b_imm ? id.imm : rt_v;
    op   = id.ex.alu_op;
    // Return address, ALU op ignored
    if (id.ex.link)
    begin
      a  = LINK_OFFSET;
      b  = id.pc_next;
      op = ALU_ADD;
    end
    sh  = a[4:0];
    msb = {1'b1, {(LEN-1){1'b0}}};
    case (op)
      ALU_ADD:  r = a + b;
      ALU_SUB:  r = a - b;
      ALU_AND:  r = a & b;
      ALU_OR:   r = a | b;
      ALU_XOR:  r = a ^ b;
      ALU_NOR:  r = ~(a | b);
      // Signed order by flipping the sign bits
      ALU_SLT:  r = LEN'((a ^ msb) < (b ^ msb));
      ALU_SLTU: r = LEN'(a < b);
      ALU_SLL:  r = b << sh;
      ALU_SRL:  r = b >> sh;
      ALU_SRA:
      begin
        ext = {{LEN{b[LEN-1]}}, b} >> sh;
        r   = ext[LEN-1:0];
      end
      ALU_LUI:  r = {b[LEN/2-1:0], {(LEN/2){1'b0}}};
      default:  r = '0;
    endcase
    e.pc_branch  = id.pc_next + id.imm;
    e.alu_result = r;
    e.store_data = rt_v;
    e.write_reg  = id.ex.reg_dst_rd ? id.rd : id.rt;
    e.zero       = (r == '0);
    e.mem        = id.mem;
    e.wb         = id.wb;
    return e;
  endfunction

  ////////////////////////////////////////
  // Checking
  ////////////////////////////////////////
  task automatic check(input string name, input logic [LEN-1:0] exp,
                       input logic [LEN-1:0] act);
    n_checks++;
    if (exp !== act)
    begin
      n_errors++;
      $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic compare_ex_mem(input ex_mem_t exp, input ex_mem_t act);
    check("o_ex_mem.pc_branch", exp.pc_branch, act.pc_branch);
    check("o_ex_mem.alu_result", exp.alu_result, act.alu_result);
    check("o_ex_mem.store_data", exp.store_data, act.store_data);
    check("o_ex_mem.write_reg", LEN'(exp.write_reg), LEN'(act.write_reg));
    check("o_ex_mem.zero", LEN'(exp.zero), LEN'(act.zero));
    check("o_ex_mem.mem", LEN'(exp.mem), LEN'(act.mem));
    check("o_ex_mem.wb", LEN'(exp.wb), LEN'(act.wb));
  endtask

`endif

// File: test/ex_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ex_tb
  import ex_pkg::*;
();

  localparam logic [LEN-1:0] LINK_OFFSET = 32'd8;
  localparam int  RST_CYCLES = 16;
  localparam int  CLK_NS     = 4;
  localparam real DRIVE_DLY  = 0.5;
  localparam int  N_OPS      = 12;
  localparam int  N_PER_OP   = 4;
  localparam int  N_FWD      = 64;
  localparam int  N_LINK     = 16;
  localparam int  N_FLUSH    = 4;
  // One idle vector closes each test
  localparam int  N_VEC = 2 * N_OPS * N_PER_OP + N_FWD + N_LINK + 3 * N_FLUSH + 5;
  localparam int  WATCHDOG_NS = N_VEC * CLK_NS * 2 + RST_CYCLES * CLK_NS;

  // Expected EX/MEM contents and the cycle they are due
  typedef struct packed {
    logic [31:0] due;
    ex_mem_t     exp;
  } chk_t;

  logic        clk;
  logic        rst_n;
  logic        flush;
  id_ex_t      id_in;
  fwd_port_t   fwd_mem;
  fwd_port_t   fwd_wb;
  ex_mem_t     ex_mem;
  chk_t        chk_q[$];
  logic [31:0] cyc;
  logic [15:0] lfsr_state;
  int          n_checks;
  int          n_errors;
  int          checks0;
  int          errors0;
  // Bypass ports belong to the EX cycle, one cycle after the vector
  fwd_port_t   pend_mem;
  fwd_port_t   pend_wb;

  `include "ex_tb_model.svh"

  ex_top #(.LINK_OFFSET(LINK_OFFSET)) u_ex_top
  (
    .i_clk     (clk),
    .i_rst_n   (rst_n),
    .i_flush   (flush),
    .i_id      (id_in),
    .i_fwd_mem (fwd_mem),
    .i_fwd_wb  (fwd_wb),
    .o_ex_mem  (ex_mem)
  );

  always #(CLK_NS / 2) clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  // Compare process, EX/MEM is stable at the falling edge
  always @(negedge clk)
  begin
    chk_t c;
    if ((chk_q.size() != 0) && (chk_q[0].due == cyc))
    begin
      c = chk_q.pop_front();
      compare_ex_mem(c.exp, ex_mem);
    end
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////
  function automatic logic [NB_REG-1:0] near_reg();
    logic [31:0] t;
    t = take_bits(2);
    return NB_REG'(t[1:0]);
  endfunction

  // Bypass data present but never selected
  function automatic fwd_port_t quiet_port();
    fwd_port_t   p;
    logic [31:0] t;
    t = take_bits(NB_REG);
    p.reg_write = 1'b0;
    p.write_reg = t[NB_REG-1:0];
    p.data      = take_bits(LEN);
    return p;
  endfunction

  // Targets r0..r3 so they collide with rs and rt often
  function automatic fwd_port_t busy_port();
    fwd_port_t   p;
    logic [31:0] t;
    t = take_bits(1);
    p.reg_write = t[0];
    p.write_reg = near_reg();
    p.data      = take_bits(LEN);
    return p;
  endfunction

  function automatic alu_op_e pick_op();
    logic [31:0] t;
    t = take_bits(4);
    return alu_op_e'(t[3:0] % 4'd12);
  endfunction

  // Random operands and pass-through groups, EX control cleared
  function automatic id_ex_t new_vector();
    id_ex_t      v;
    logic [31:0] t;
    v         = '0;
    v.pc_next = take_bits(LEN);
    v.rs_data = take_bits(LEN);
    v.rt_data = take_bits(LEN);
    t         = take_bits(16);
    v.imm     = {{16{t[15]}}, t[15:0]};
    t         = take_bits(4 * NB_REG);
    {v.rs, v.rt, v.rd, v.shamt} = t[4*NB_REG-1:0];
    t         = take_bits(11);
    {v.mem, v.wb} = t[10:0];
    return v;
  endfunction

  task automatic drive(input id_ex_t id, input logic fl, input fwd_port_t mem,
                       input fwd_port_t wb, input logic expect_it);
    chk_t c;
    @(posedge clk);
    #(DRIVE_DLY);
    id_in    = id;
    flush    = fl;
    fwd_mem  = pend_mem;
    fwd_wb   = pend_wb;
    pend_mem = mem;
    pend_wb  = wb;
    if (expect_it)
    begin
      c.due = cyc + 2;
      // A flushed slot executes as an all-zero ID/EX word
      c.exp = fl ? exp_ex_mem('0, mem, wb) : exp_ex_mem(id, mem, wb);
      chk_q.push_back(c);
    end
  endtask

  task automatic start_test();
    checks0 = n_checks;
    errors0 = n_errors;
  endtask

  task automatic end_test(input string name);
    drive('0, 1'b0, '0, '0, 1'b0);
    while (chk_q.size() != 0)
      @(posedge clk);
    $display("%-10s %0d checks, %0d errors", name, n_checks - checks0, n_errors - errors0);
  endtask

  ////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////
  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog: run timed out after %0d ns", WATCHDOG_NS);
    $display("Done: errors found");
    $finish;
  end

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////
  initial
  begin
    id_ex_t id;
    int     op;
    int     k;
    clk        = 1'b0;
    rst_n      = 1'b0;
    flush      = 1'b0;
    id_in      = '0;
    fwd_mem    = '0;
    fwd_wb     = '0;
    pend_mem   = '0;
    pend_wb    = '0;
    cyc        = '0;
    lfsr_state = 16'd59;
    n_checks   = 0;
    n_errors   = 0;

    start_test();
    repeat (RST_CYCLES) @(posedge clk);
    #(DRIVE_DLY);
    compare_ex_mem('0, ex_mem);
    rst_n = 1'b1;
    $display("%-10s %0d checks, %0d errors", "reset", n_checks - checks0, n_errors - errors0);

    // Register-register over every op, no bypass
    start_test();
    for (op = 0; op < N_OPS; op++)
      for (k = 0; k < N_PER_OP; k++)
      begin
        id = new_vector();
        id.ex.alu_op     = alu_op_e'(op[3:0]);
        id.ex.reg_dst_rd = 1'b1;
        if (k == 0)
          id.rt_data = id.rs_data;
        drive(id, 1'b0, quiet_port(), quiet_port(), 1'b1);
      end
    end_test("reg_reg");

    // Immediate on B, shamt on A for the shifts
    start_test();
    for (op = 0; op < N_OPS; op++)
      for (k = 0; k < N_PER_OP; k++)
      begin
        id = new_vector();
        id.ex.alu_op = alu_op_e'(op[3:0]);
        if (id.ex.alu_op inside {ALU_SLL, ALU_SRL, ALU_SRA})
        begin
          id.ex.src_a_shamt = 1'b1;
          id.ex.src_b_imm   = k[0];
        end
        else
          id.ex.src_b_imm = 1'b1;
        drive(id, 1'b0, quiet_port(), quiet_port(), 1'b1);
      end
    end_test("imm_shamt");

    start_test();
    for (k = 0; k < N_FWD; k++)
    begin
      id = new_vector();
      id.rs            = near_reg();
      id.rt            = near_reg();
      id.ex.alu_op     = pick_op();
      id.ex.reg_dst_rd = k[0];
      drive(id, 1'b0, busy_port(), busy_port(), 1'b1);
    end
    end_test("forward");

    start_test();
    for (k = 0; k < N_LINK; k++)
    begin
      id = new_vector();
      id.ex.alu_op      = pick_op();
      id.ex.link        = 1'b1;
      id.ex.src_a_shamt = k[0];
      id.ex.src_b_imm   = k[1];
      drive(id, 1'b0, quiet_port(), quiet_port(), 1'b1);
    end
    end_test("link");

    // Neighbours of a flushed slot must come through intact
    start_test();
    for (k = 0; k < N_FLUSH; k++)
    begin
      id = new_vector();
      id.ex.alu_op = pick_op();
      drive(id, 1'b0, busy_port(), busy_port(), 1'b1);
      id = new_vector();
      id.ex.alu_op = pick_op();
      drive(id, 1'b1, busy_port(), busy_port(), 1'b1);
      id = new_vector();
      id.ex.alu_op = pick_op();
      drive(id, 1'b0, busy_port(), busy_port(), 1'b1);
    end
    end_test("flush");

    $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/ex_top.sv
`timescale 1ns/1ps
`default_nettype none

module ex_top
  import ex_pkg::*;
#(
  parameter logic [LEN-1:0] LINK_OFFSET = 'd8
)
(
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  logic      i_flush,
  input  id_ex_t    i_id,
  input  fwd_port_t i_fwd_mem,
  input  fwd_port_t i_fwd_wb,
  output ex_mem_t   o_ex_mem
);

  id_ex_t   id_ex;
  ex_mem_t  ex_next;
  fwd_src_e fwd_a;
  fwd_src_e fwd_b;

  // ID/EX, a flush turns the next EX cycle into a bubble
  pipe_reg #(.T(id_ex_t)) u_id_ex
  (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_flush (i_flush),
    .i_d     (i_id),
    .o_q     (id_ex)
  );

  forward_unit u_forward_unit
  (
    .i_rs      (id_ex.rs),
    .i_rt      (id_ex.rt),
    .i_fwd_mem (i_fwd_mem),
    .i_fwd_wb  (i_fwd_wb),
    .o_fwd_a   (fwd_a),
    .o_fwd_b   (fwd_b)
  );

  ex_stage #(.LINK_OFFSET(LINK_OFFSET)) u_ex_stage
  (
    .i_id      (id_ex),
    .i_fwd_a   (fwd_a),
    .i_fwd_b   (fwd_b),
    .i_fwd_mem (i_fwd_mem),
    .i_fwd_wb  (i_fwd_wb),
    .o_ex      (ex_next)
  );

  pipe_reg #(.T(ex_mem_t)) u_ex_mem
  (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_flush (1'b0),
    .i_d     (ex_next),
    .o_q     (o_ex_mem)
  );

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Flushed slot reaches EX/MEM one edge after ID/EX
  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_flush |-> ##2 !o_ex_mem.wb.reg_write)
    else $error("ex_top: flushed slot writes the register file");

endmodule

`default_nettype wire

// File: verilog/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage
  import ex_pkg::*;
#(
  parameter logic [LEN-1:0] LINK_OFFSET = LEN'(8)
)
(
  input  id_ex_t    i_id,
  input  fwd_src_e  i_fwd_a,
  input  fwd_src_e  i_fwd_b,
  input  fwd_port_t i_fwd_mem,
  input  fwd_port_t i_fwd_wb,
  output ex_mem_t   o_ex
);

  logic [LEN-1:0] alu_a;
  logic [LEN-1:0] alu_b;
  logic [LEN-1:0] alu_result;
  logic [LEN-1:0] store_data;
  logic           alu_zero;
  alu_op_e        alu_op;

  ////////////////////////////////////////
  // Operands
  ////////////////////////////////////////
  operand_select
  #(
    .LINK_OFFSET (LINK_OFFSET)
  )
  u_operand_select
  (
    .i_id         (i_id),
    .i_fwd_a      (i_fwd_a),
    .i_fwd_b      (i_fwd_b),
    .i_mem_data   (i_fwd_mem.data),
    .i_wb_data    (i_fwd_wb.data),
    .o_a          (alu_a),
    .o_b          (alu_b),
    .o_store_data (store_data)
  );

  // Link always adds, whatever decode put in alu_op
  always_comb
  begin
    if (i_id.ex.link)
      alu_op = ALU_ADD;
    else
      alu_op = i_id.ex.alu_op;
  end

  alu u_alu
  (
    .i_a      (alu_a),
    .i_b      (alu_b),
    .i_op     (alu_op),
    .o_result (alu_result),
    .o_zero   (alu_zero)
  );

  ////////////////////////////////////////
  // EX/MEM next value
  ////////////////////////////////////////
  always_comb
  begin
    o_ex.pc_branch  = i_id.pc_next + i_id.imm;
    o_ex.alu_result = alu_result;
    o_ex.store_data = store_data;
    // R-type writes rd, I-type writes rt
    o_ex.write_reg  = i_id.ex.reg_dst_rd ? i_id.rd : i_id.rt;
    o_ex.zero       = alu_zero;
    o_ex.mem        = i_id.mem;
    o_ex.wb         = i_id.wb;
  end

endmodule

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
  import ex_pkg::*;
(
  input  logic [LEN-1:0] i_a,
  input  logic [LEN-1:0] i_b,
  input  alu_op_e        i_op,
  output logic [LEN-1:0] o_result,
  output logic           o_zero
);

  localparam int NB_SHIFT = $clog2(LEN);

  logic [NB_SHIFT-1:0] sh;
  logic [LEN-1:0]      result;

  // Shift amount comes in on A, the value on B
  assign sh = i_a[NB_SHIFT-1:0];

  ////////////////////////////////////////
  // Operations
  ////////////////////////////////////////
  always_comb
  begin
    case (i_op)
      ALU_ADD:  result = i_a + i_b;
      ALU_SUB:  result = i_a - i_b;
      ALU_AND:  result = i_a & i_b;
      ALU_OR:   result = i_a | i_b;
      ALU_XOR:  result = i_a ^ i_b;
      ALU_NOR:  result = ~(i_a | i_b);
      ALU_SLT:  result = {{(LEN-1){1'b0}}, ($signed(i_a) < $signed(i_b))};
      ALU_SLTU: result = {{(LEN-1){1'b0}}, (i_a < i_b)};
      ALU_SLL:  result = i_b << sh;
      ALU_SRL:  result = i_b >> sh;
      ALU_SRA:  result = $unsigned($signed(i_b) >>> sh);
      ALU_LUI:  result = {i_b[LEN/2-1:0], {(LEN/2){1'b0}}};
      default:  result = '0;
    endcase
  end

  assign o_result = result;
  // Feeds beq/bne in MEM
  assign o_zero   = (result == '0);

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // A decoded op out of reset must give a clean result
  always_comb
  begin
    if (i_op <= ALU_LUI)
    begin
      assert final (!$isunknown(o_result))
        else $error("alu: unknown result for op %0d", i_op);
    end
  end

endmodule

`default_nettype wire

// File: verilog/operand_select.sv
`timescale 1ns/1ps
`default_nettype none

module operand_select
  import ex_pkg::*;
#(
  parameter logic [LEN-1:0] LINK_OFFSET = LEN'(8)
)
(
  input  id_ex_t         i_id,
  input  fwd_src_e       i_fwd_a,
  input  fwd_src_e       i_fwd_b,
  input  logic [LEN-1:0] i_mem_data,
  input  logic [LEN-1:0] i_wb_data,
  output logic [LEN-1:0] o_a,
  output logic [LEN-1:0] o_b,
  output logic [LEN-1:0] o_store_data
);

  logic [LEN-1:0] rs_val;
  logic [LEN-1:0] rt_val;
  logic [LEN-1:0] a_pre;
  logic [LEN-1:0] b_pre;

  function automatic logic [LEN-1:0] fwd_mux(
    input fwd_src_e       sel,
    input logic [LEN-1:0] rf_data,
    input logic [LEN-1:0] mem_data,
    input logic [LEN-1:0] wb_data
  );
    logic [LEN-1:0] val;
    case (sel)
      FWD_MEM: val = mem_data;
      FWD_WB:  val = wb_data;
      default: val = rf_data;
    endcase
    return val;
  endfunction

  ////////////////////////////////////////
  // Bypass muxes
  ////////////////////////////////////////
  assign rs_val = fwd_mux(i_fwd_a, i_id.rs_data, i_mem_data, i_wb_data);
  assign rt_val = fwd_mux(i_fwd_b, i_id.rt_data, i_mem_data, i_wb_data);

  // Stores need the bypassed rt too
  assign o_store_data = rt_val;

  ////////////////////////////////////////
  // ALU source muxes
  ////////////////////////////////////////
  assign a_pre = i_id.ex.src_a_shamt ? {{(LEN-NB_REG){1'b0}}, i_id.shamt} : rs_val;
  assign b_pre = i_id.ex.src_b_imm ? i_id.imm : rt_val;

  // Link: return address = pc_next + offset
  assign o_a = i_id.ex.link ? LINK_OFFSET : a_pre;
  assign o_b = i_id.ex.link ? i_id.pc_next : b_pre;

endmodule

`default_nettype wire

// File: verilog/forward_unit.sv
`timescale 1ns/1ps
`default_nettype none

module forward_unit
  import ex_pkg::*;
(
  input  logic [NB_REG-1:0] i_rs,
  input  logic [NB_REG-1:0] i_rt,
  input  fwd_port_t         i_fwd_mem,
  input  fwd_port_t         i_fwd_wb,
  output fwd_src_e          o_fwd_a,
  output fwd_src_e          o_fwd_b
);

  // MEM holds the younger write, so it is checked first
  function automatic fwd_src_e pick_src(
    input logic [NB_REG-1:0] src,
    input fwd_port_t         mem,
    input fwd_port_t         wb
  );
    fwd_src_e sel;
    sel = FWD_RF;
    // r0 is hardwired, never take a bypass for it
    if (src != '0)
    begin
      if (mem.reg_write && (mem.write_reg == src))
        sel = FWD_MEM;
      else if (wb.reg_write && (wb.write_reg == src))
        sel = FWD_WB;
    end
    return sel;
  endfunction

  assign o_fwd_a = pick_src(i_rs, i_fwd_mem, i_fwd_wb);
  assign o_fwd_b = pick_src(i_rt, i_fwd_mem, i_fwd_wb);

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////
  always_comb
  begin
    assert final ((i_rs != '0) || (o_fwd_a == FWD_RF))
      else $error("forward_unit: bypass selected for rs = r0");
    assert final ((i_rt != '0) || (o_fwd_b == FWD_RF))
      else $error("forward_unit: bypass selected for rt = r0");
  end

endmodule

`default_nettype wire

// File: verilog/pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_reg
#(
  parameter type T = logic
)
(
  input  logic i_clk,
  input  logic i_rst_n,
  input  logic i_flush,
  input  T     i_d,
  output T     o_q
);

  ////////////////////////////////////////
  // Stage register
  ////////////////////////////////////////

  // All-zero payload is a bubble: no writes, no memory access
  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n || i_flush)
    begin
      o_q <= '0;
    end
    else
    begin
      o_q <= i_d;
    end
  end

endmodule

`default_nettype wire

// File: verilog/ex_pkg.sv
`default_nettype none

package ex_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////
  localparam int LEN       = 32;
  localparam int NB_REG    = 5;
  localparam int NB_ALU_OP = 4;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  // Zero is add, so a bubble decodes harmlessly
  typedef enum logic [NB_ALU_OP-1:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_NOR  = 4'd5,
    ALU_SLT  = 4'd6,
    ALU_SLTU = 4'd7,
    ALU_SLL  = 4'd8,
    ALU_SRL  = 4'd9,
    ALU_SRA  = 4'd10,
    ALU_LUI  = 4'd11
  } alu_op_e;

  typedef enum logic [1:0] {
    FWD_RF  = 2'd0,
    FWD_MEM = 2'd1,
    FWD_WB  = 2'd2
  } fwd_src_e;

  ////////////////////////////////////////
  // Control groups
  ////////////////////////////////////////
  typedef struct packed {
    alu_op_e alu_op;
    logic    src_a_shamt;
    logic    src_b_imm;
    logic    reg_dst_rd;
    logic    link;
  } ex_ctrl_t;

  // Only carried through EX, used further down the pipe
  typedef struct packed {
    logic       mem_read;
    logic       mem_write;
    logic [1:0] mem_size;
    logic       mem_unsigned;
    logic       branch_eq;
    logic       branch_ne;
    logic       jump;
    logic       jump_reg;
  } mem_ctrl_t;

  typedef struct packed {
    logic reg_write;
    logic mem_to_reg;
  } wb_ctrl_t;

  ////////////////////////////////////////
  // Pipeline registers
  ////////////////////////////////////////
  typedef struct packed {
    logic [LEN-1:0]    pc_next;
    logic [LEN-1:0]    rs_data;
    logic [LEN-1:0]    rt_data;
    logic [LEN-1:0]    imm;
    logic [NB_REG-1:0] rs;
    logic [NB_REG-1:0] rt;
    logic [NB_REG-1:0] rd;
    logic [NB_REG-1:0] shamt;
    ex_ctrl_t          ex;
    mem_ctrl_t         mem;
    wb_ctrl_t          wb;
  } id_ex_t;

  typedef struct packed {
    logic [LEN-1:0]    pc_branch;
    logic [LEN-1:0]    alu_result;
    logic [LEN-1:0]    store_data;
    logic [NB_REG-1:0] write_reg;
    logic              zero;
    mem_ctrl_t         mem;
    wb_ctrl_t          wb;
  } ex_mem_t;

  // Result of a later stage, offered back to EX
  typedef struct packed {
    logic              reg_write;
    logic [NB_REG-1:0] write_reg;
    logic [LEN-1:0]    data;
  } fwd_port_t;

endpackage

`default_nettype wire
